// ==== design/core_pkg.sv ====
package core_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      reg_addr_t;

  // Major opcodes of the supported subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  // Operand source for the EX stage
  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_EXMEM,
    FWD_MEMWB
  } fwd_sel_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src_imm;
    logic    reg_we;
    logic    mem_read;
    logic    mem_write;
    logic    is_branch;
    logic    branch_ne;
    logic    is_jal;
  } ctrl_t;

  typedef struct packed {
    logic  valid;
    word_t pc;
    inst_t inst;
  } ifid_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    ctrl_t     ctrl;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
  } idex_t;

  typedef struct packed {
    logic      valid;
    ctrl_t     ctrl;
    reg_addr_t rd;
    word_t     result;
    word_t     store_data;
  } exmem_t;

  // reg_we here is already cleared for rd == x0
  typedef struct packed {
    logic      valid;
    logic      reg_we;
    reg_addr_t rd;
    word_t     value;
  } memwb_t;

endpackage

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
  parameter int              IMEM_DEPTH = 256,
  parameter core_pkg::word_t RESET_PC   = '0
) (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_imem_we,
  input  core_pkg::word_t i_imem_addr,
  input  core_pkg::inst_t i_imem_wdata,
  input  logic            i_stall,
  input  logic            i_flush,
  input  logic            i_take,
  input  core_pkg::word_t i_target,
  output core_pkg::ifid_t o_ifid
);

  localparam int IDX_W = $clog2(IMEM_DEPTH);

  core_pkg::inst_t imem [IMEM_DEPTH];
  core_pkg::word_t pc_q;
  core_pkg::word_t pc_next;
  core_pkg::inst_t fetched;
  core_pkg::ifid_t ifid_q;

  // Program load port, word addressed
  always_ff @(posedge i_clk) begin
    if (i_imem_we) begin
      imem[i_imem_addr[IDX_W-1:0]] <= i_imem_wdata;
    end
  end

  assign fetched = imem[pc_q[IDX_W+1:2]];

  // Redirect from EX wins over a stall
  always_comb begin
    if (i_take) begin
      pc_next = i_target;
    end else if (i_stall) begin
      pc_next = pc_q;
    end else begin
      pc_next = pc_q + 32'd4;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pc_q         <= RESET_PC;
      ifid_q.valid <= 1'b0;
    end else begin
      pc_q <= pc_next;
      if (i_flush) begin
        ifid_q.valid <= 1'b0;
      end else if (!i_stall) begin
        ifid_q.valid <= 1'b1;
        ifid_q.pc    <= pc_q;
        ifid_q.inst  <= fetched;
      end
    end
  end

  assign o_ifid = ifid_q;

endmodule

// ==== design/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  core_pkg::ifid_t     i_ifid,
  input  core_pkg::word_t     i_rs1_data,
  input  core_pkg::word_t     i_rs2_data,
  input  logic                i_stall,
  input  logic                i_flush,
  output core_pkg::reg_addr_t o_rs1_addr,
  output core_pkg::reg_addr_t o_rs2_addr,
  output core_pkg::idex_t     o_idex
);

  core_pkg::inst_t inst;
  core_pkg::ctrl_t ctrl;
  core_pkg::word_t imm;
  core_pkg::word_t imm_i;
  core_pkg::word_t imm_s;
  core_pkg::word_t imm_b;
  core_pkg::word_t imm_u;
  core_pkg::word_t imm_j;
  logic            use_rs1;
  logic            use_rs2;
  core_pkg::idex_t idex_q;

  assign inst  = i_ifid.inst;
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // Anything outside the subset stays a no-op
  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = core_pkg::ALU_ADD;
    imm         = imm_i;
    use_rs1     = 1'b0;
    use_rs2     = 1'b0;
    case (inst[6:0])
      core_pkg::OPC_OP: begin
        ctrl.reg_we = 1'b1;
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
        // funct7 and funct3 together
        case ({inst[31:25], inst[14:12]})
          10'b0000000_000: ctrl.alu_op = core_pkg::ALU_ADD;
          10'b0100000_000: ctrl.alu_op = core_pkg::ALU_SUB;
          10'b0000000_111: ctrl.alu_op = core_pkg::ALU_AND;
          10'b0000000_110: ctrl.alu_op = core_pkg::ALU_OR;
          10'b0000000_100: ctrl.alu_op = core_pkg::ALU_XOR;
          10'b0000000_010: ctrl.alu_op = core_pkg::ALU_SLT;
          default: begin
            ctrl.reg_we = 1'b0;
            use_rs1     = 1'b0;
            use_rs2     = 1'b0;
          end
        endcase
      end
      core_pkg::OPC_OP_IMM: begin
        // ADDI only
        if (inst[14:12] == 3'b000) begin
          ctrl.alu_src_imm = 1'b1;
          ctrl.reg_we      = 1'b1;
          use_rs1          = 1'b1;
        end
      end
      core_pkg::OPC_LUI: begin
        ctrl.alu_op      = core_pkg::ALU_PASS_B;
        ctrl.alu_src_imm = 1'b1;
        ctrl.reg_we      = 1'b1;
        imm              = imm_u;
      end
      core_pkg::OPC_LOAD: begin
        if (inst[14:12] == 3'b010) begin
          ctrl.alu_src_imm = 1'b1;
          ctrl.reg_we      = 1'b1;
          ctrl.mem_read    = 1'b1;
          use_rs1          = 1'b1;
        end
      end
      core_pkg::OPC_STORE: begin
        if (inst[14:12] == 3'b010) begin
          ctrl.alu_src_imm = 1'b1;
          ctrl.mem_write   = 1'b1;
          imm              = imm_s;
          use_rs1          = 1'b1;
          use_rs2          = 1'b1;
        end
      end
      core_pkg::OPC_BRANCH: begin
        // BEQ is 000, BNE is 001
        if (inst[14:13] == 2'b00) begin
          ctrl.is_branch = 1'b1;
          ctrl.branch_ne = inst[12];
          imm            = imm_b;
          use_rs1        = 1'b1;
          use_rs2        = 1'b1;
        end
      end
      core_pkg::OPC_JAL: begin
        ctrl.is_jal = 1'b1;
        ctrl.reg_we = 1'b1;
        imm         = imm_j;
      end
      default: begin
      end
    endcase
  end

  // Unused sources read as x0 so they never match a hazard
  assign o_rs1_addr = (i_ifid.valid && use_rs1) ? inst[19:15] : '0;
  assign o_rs2_addr = (i_ifid.valid && use_rs2) ? inst[24:20] : '0;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      idex_q.valid <= 1'b0;
    end else begin
      idex_q.valid <= i_ifid.valid && !i_stall && !i_flush;
    end
  end

  always_ff @(posedge i_clk) begin
    idex_q.pc       <= i_ifid.pc;
    idex_q.ctrl     <= ctrl;
    idex_q.rs1_addr <= o_rs1_addr;
    idex_q.rs2_addr <= o_rs2_addr;
    idex_q.rd       <= inst[11:7];
    idex_q.rs1_val  <= i_rs1_data;
    idex_q.rs2_val  <= i_rs2_data;
    idex_q.imm      <= imm;
  end

  assign o_idex = idex_q;

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/1ps

module register_file (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_we,
  input  core_pkg::reg_addr_t i_waddr,
  input  core_pkg::word_t     i_wdata,
  input  core_pkg::reg_addr_t i_rs1_addr,
  input  core_pkg::reg_addr_t i_rs2_addr,
  output core_pkg::word_t     o_rs1_data,
  output core_pkg::word_t     o_rs2_data
);

  core_pkg::word_t regs [32];
  logic            wr_en;

  // x0 is never written
  assign wr_en = i_we && (i_waddr != '0);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // Write-through so decode sees the value retiring this cycle
  function automatic core_pkg::word_t read_port(
    input core_pkg::reg_addr_t addr,
    input logic                we,
    input core_pkg::reg_addr_t waddr,
    input core_pkg::word_t     wdata,
    input core_pkg::word_t     stored
  );
    if (addr == '0) begin
      return '0;
    end
    if (we && (waddr == addr)) begin
      return wdata;
    end
    return stored;
  endfunction

  assign o_rs1_data = read_port(i_rs1_addr, wr_en, i_waddr, i_wdata, regs[i_rs1_addr]);
  assign o_rs2_data = read_port(i_rs2_addr, wr_en, i_waddr, i_wdata, regs[i_rs2_addr]);

endmodule

// ==== design/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  core_pkg::idex_t    i_idex,
  input  core_pkg::fwd_sel_e i_fwd_a,
  input  core_pkg::fwd_sel_e i_fwd_b,
  input  core_pkg::word_t    i_exmem_result,
  input  core_pkg::word_t    i_memwb_value,
  output logic               o_take,
  output core_pkg::word_t    o_target,
  output core_pkg::exmem_t   o_exmem
);

  core_pkg::word_t  op_a;
  core_pkg::word_t  op_b;
  core_pkg::word_t  alu_b;
  core_pkg::word_t  alu_out;
  core_pkg::word_t  result;
  logic             operands_eq;
  core_pkg::exmem_t exmem_q;

  function automatic core_pkg::word_t fwd_pick(
    input core_pkg::fwd_sel_e sel,
    input core_pkg::word_t    reg_val,
    input core_pkg::word_t    exmem_val,
    input core_pkg::word_t    memwb_val
  );
    case (sel)
      core_pkg::FWD_EXMEM: return exmem_val;
      core_pkg::FWD_MEMWB: return memwb_val;
      default:             return reg_val;
    endcase
  endfunction

  assign op_a  = fwd_pick(i_fwd_a, i_idex.rs1_val, i_exmem_result, i_memwb_value);
  assign op_b  = fwd_pick(i_fwd_b, i_idex.rs2_val, i_exmem_result, i_memwb_value);
  assign alu_b = i_idex.ctrl.alu_src_imm ? i_idex.imm : op_b;

  always_comb begin
    case (i_idex.ctrl.alu_op)
      core_pkg::ALU_SUB:    alu_out = op_a - alu_b;
      core_pkg::ALU_AND:    alu_out = op_a & alu_b;
      core_pkg::ALU_OR:     alu_out = op_a | alu_b;
      core_pkg::ALU_XOR:    alu_out = op_a ^ alu_b;
      core_pkg::ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(alu_b)};
      core_pkg::ALU_PASS_B: alu_out = alu_b;
      default:              alu_out = op_a + alu_b;
    endcase
  end

  // JAL links the return address
  assign result = i_idex.ctrl.is_jal ? i_idex.pc + 32'd4 : alu_out;

  // Branch compare uses the register operands, not the ALU B input
  assign operands_eq = (op_a == op_b);
  assign o_take      = i_idex.valid &&
                       (i_idex.ctrl.is_jal ||
                        (i_idex.ctrl.is_branch && (operands_eq != i_idex.ctrl.branch_ne)));
  assign o_target    = i_idex.pc + i_idex.imm;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      exmem_q.valid <= 1'b0;
    end else begin
      exmem_q.valid <= i_idex.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    exmem_q.ctrl       <= i_idex.ctrl;
    exmem_q.rd         <= i_idex.rd;
    exmem_q.result     <= result;
    exmem_q.store_data <= op_b;
  end

  assign o_exmem = exmem_q;

endmodule

// ==== design/memory_unit.sv ====
`timescale 1ns/1ps

module memory_unit #(
  parameter int DMEM_DEPTH = 256
) (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  core_pkg::exmem_t i_exmem,
  output core_pkg::memwb_t o_memwb
);

  localparam int IDX_W = $clog2(DMEM_DEPTH);

  core_pkg::word_t  dmem [DMEM_DEPTH];
  logic [IDX_W-1:0] dmem_idx;
  core_pkg::word_t  load_data;
  core_pkg::memwb_t memwb_q;

  // Word addressed, low two address bits ignored
  assign dmem_idx  = i_exmem.result[IDX_W+1:2];
  assign load_data = dmem[dmem_idx];

  always_ff @(posedge i_clk) begin
    if (i_exmem.valid && i_exmem.ctrl.mem_write) begin
      dmem[dmem_idx] <= i_exmem.store_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      memwb_q.valid <= 1'b0;
    end else begin
      memwb_q.valid <= i_exmem.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    memwb_q.reg_we <= i_exmem.ctrl.reg_we && (i_exmem.rd != '0);
    memwb_q.rd     <= i_exmem.rd;
    memwb_q.value  <= i_exmem.ctrl.mem_read ? load_data : i_exmem.result;
  end

  assign o_memwb = memwb_q;

endmodule

// ==== design/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
  input  core_pkg::idex_t     i_idex,
  input  core_pkg::exmem_t    i_exmem,
  input  core_pkg::memwb_t    i_memwb,
  input  core_pkg::reg_addr_t i_rs1_addr,
  input  core_pkg::reg_addr_t i_rs2_addr,
  input  logic                i_take,
  output logic                o_stall,
  output logic                o_flush,
  output core_pkg::fwd_sel_e  o_fwd_a,
  output core_pkg::fwd_sel_e  o_fwd_b
);

  logic load_use;

  // Youngest writer first
  function automatic core_pkg::fwd_sel_e pick_fwd(
    input core_pkg::reg_addr_t src,
    input core_pkg::exmem_t    exmem,
    input core_pkg::memwb_t    memwb
  );
    if (exmem.valid && exmem.ctrl.reg_we && (exmem.rd != '0) && (exmem.rd == src)) begin
      return core_pkg::FWD_EXMEM;
    end
    if (memwb.valid && memwb.reg_we && (memwb.rd == src)) begin
      return core_pkg::FWD_MEMWB;
    end
    return core_pkg::FWD_NONE;
  endfunction

  assign o_fwd_a = pick_fwd(i_idex.rs1_addr, i_exmem, i_memwb);
  assign o_fwd_b = pick_fwd(i_idex.rs2_addr, i_exmem, i_memwb);

  // Load data only exists after MEM, so the consumer waits one cycle
  assign load_use = i_idex.valid && i_idex.ctrl.mem_read && (i_idex.rd != '0) &&
                    ((i_idex.rd == i_rs1_addr) || (i_idex.rd == i_rs2_addr));

  assign o_flush = i_take;
  assign o_stall = load_use && !i_take;

endmodule

// ==== design/processor_core.sv ====
`timescale 1ns/1ps

module processor_core #(
  parameter int              IMEM_DEPTH = 256,
  parameter int              DMEM_DEPTH = 256,
  parameter core_pkg::word_t RESET_PC   = '0
) (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_imem_we,
  input  core_pkg::word_t     i_imem_addr,
  input  core_pkg::inst_t     i_imem_wdata,
  output logic                o_retire_valid,
  output core_pkg::reg_addr_t o_retire_rd,
  output core_pkg::word_t     o_retire_value
);

  core_pkg::ifid_t     ifid;
  core_pkg::idex_t     idex;
  core_pkg::exmem_t    exmem;
  core_pkg::memwb_t    memwb;
  core_pkg::reg_addr_t rs1_addr;
  core_pkg::reg_addr_t rs2_addr;
  core_pkg::word_t     rs1_data;
  core_pkg::word_t     rs2_data;
  core_pkg::fwd_sel_e  fwd_a;
  core_pkg::fwd_sel_e  fwd_b;
  core_pkg::word_t     target;
  logic                take;
  logic                stall;
  logic                flush;
  logic                wb_we;

  // Writeback and retire share one enable
  assign wb_we = memwb.valid && memwb.reg_we;

  fetch_unit #(
    .IMEM_DEPTH(IMEM_DEPTH),
    .RESET_PC  (RESET_PC)
  ) u_fetch (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_imem_we   (i_imem_we),
    .i_imem_addr (i_imem_addr),
    .i_imem_wdata(i_imem_wdata),
    .i_stall     (stall),
    .i_flush     (flush),
    .i_take      (take),
    .i_target    (target),
    .o_ifid      (ifid)
  );

  decode_unit u_decode (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_ifid    (ifid),
    .i_rs1_data(rs1_data),
    .i_rs2_data(rs2_data),
    .i_stall   (stall),
    .i_flush   (flush),
    .o_rs1_addr(rs1_addr),
    .o_rs2_addr(rs2_addr),
    .o_idex    (idex)
  );

  register_file u_regfile (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_we      (wb_we),
    .i_waddr   (memwb.rd),
    .i_wdata   (memwb.value),
    .i_rs1_addr(rs1_addr),
    .i_rs2_addr(rs2_addr),
    .o_rs1_data(rs1_data),
    .o_rs2_data(rs2_data)
  );

  execute_unit u_execute (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_idex        (idex),
    .i_fwd_a       (fwd_a),
    .i_fwd_b       (fwd_b),
    .i_exmem_result(exmem.result),
    .i_memwb_value (memwb.value),
    .o_take        (take),
    .o_target      (target),
    .o_exmem       (exmem)
  );

  memory_unit #(
    .DMEM_DEPTH(DMEM_DEPTH)
  ) u_memory (
    .i_clk  (i_clk),
    .i_rst_n(i_rst_n),
    .i_exmem(exmem),
    .o_memwb(memwb)
  );

  hazard_unit u_hazard (
    .i_idex    (idex),
    .i_exmem   (exmem),
    .i_memwb   (memwb),
    .i_rs1_addr(rs1_addr),
    .i_rs2_addr(rs2_addr),
    .i_take    (take),
    .o_stall   (stall),
    .o_flush   (flush),
    .o_fwd_a   (fwd_a),
    .o_fwd_b   (fwd_b)
  );

  assign o_retire_valid = wb_we;
  assign o_retire_rd    = memwb.rd;
  assign o_retire_value = memwb.value;

endmodule

// ==== tests/processor_core_asserts.sv ====
`timescale 1ns/1ps

module processor_core_asserts (
  input logic                i_clk,
  input logic                i_rst_n,
  input logic                i_retire_valid,
  input core_pkg::reg_addr_t i_retire_rd,
  input logic                i_stall,
  input logic                i_flush,
  input core_pkg::ifid_t     i_ifid,
  input core_pkg::idex_t     i_idex
);

  // x0 writes are dropped before MEM/WB
  retire_rd_nonzero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_retire_valid |-> (i_retire_rd != '0))
    else $error("retire reported for x0");

  retire_low_after_reset: assert property (@(posedge i_clk)
    !i_rst_n |=> !i_retire_valid)
    else $error("retire pulse right after a reset cycle");

  // Branch shadow is cleared from both younger stages
  flush_kills_shadow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_flush |=> (!i_ifid.valid && !i_idex.valid))
    else $error("instruction in branch shadow survived a flush");

  stall_inserts_bubble: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_stall |=> !i_idex.valid)
    else $error("load-use stall did not insert a bubble");

endmodule

bind processor_core processor_core_asserts u_asserts (
  .i_clk         (i_clk),
  .i_rst_n       (i_rst_n),
  .i_retire_valid(o_retire_valid),
  .i_retire_rd   (o_retire_rd),
  .i_stall       (stall),
  .i_flush       (flush),
  .i_ifid        (ifid),
  .i_idex        (idex)
);

// ==== tests/processor_core_tb.sv ====
`timescale 1ns/1ps

module processor_core_tb;

  localparam int IMEM_DEPTH     = 256;
  localparam int DMEM_DEPTH     = 256;
  localparam int IDX_W          = $clog2(IMEM_DEPTH);
  localparam int RESET_CYCLES   = 5;
  localparam int RETIRE_TIMEOUT = 50;
  localparam int IDLE_CYCLES    = 20;

  logic                clk;
  logic                rst_n;
  logic                imem_we;
  core_pkg::word_t     imem_addr;
  core_pkg::inst_t     imem_wdata;
  logic                retire_valid;
  core_pkg::reg_addr_t retire_rd;
  core_pkg::word_t     retire_value;

  // Program image and expected retire stream of the current test
  core_pkg::inst_t     prog [IMEM_DEPTH];
  core_pkg::reg_addr_t exp_rd [$];
  core_pkg::word_t     exp_value [$];
  string               test_name;
  int                  tests_run;

  processor_core #(
    .IMEM_DEPTH(IMEM_DEPTH),
    .DMEM_DEPTH(DMEM_DEPTH),
    .RESET_PC  ('0)
  ) u_dut (
    .i_clk         (clk),
    .i_rst_n       (rst_n),
    .i_imem_we     (imem_we),
    .i_imem_addr   (imem_addr),
    .i_imem_wdata  (imem_wdata),
    .o_retire_valid(retire_valid),
    .o_retire_rd   (retire_rd),
    .o_retire_value(retire_value)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic clear_test();
    foreach (prog[a]) begin
      prog[a] = '0;
    end
    exp_rd.delete();
    exp_value.delete();
  endtask

  // Whole memory is written so stale words never leak into the next test
  task automatic load_program();
    rst_n = 1'b0;
    for (int a = 0; a < IMEM_DEPTH; a++) begin
      imem_we    = 1'b1;
      imem_addr  = core_pkg::word_t'(a);
      imem_wdata = prog[imem_addr[IDX_W-1:0]];
      @(negedge clk);
    end
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic expect_retire(
    input core_pkg::reg_addr_t rd,
    input core_pkg::word_t     value,
    input int                  idx
  );
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!retire_valid && cycles < RETIRE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!retire_valid) begin
      stop_on_error($sformatf("Test %s timed out after %0d cycles waiting for retire %0d",
                              test_name, RETIRE_TIMEOUT, idx));
    end else begin
      assert (retire_rd == rd && retire_value == value)
        else stop_on_error($sformatf(
          "** Error at time %0t: test %s retire %0d expected x%0d = %h, got x%0d = %h",
          $time, test_name, idx, rd, value, retire_rd, retire_value));
    end
  endtask

  // Nothing may retire once the expected stream is done
  task automatic check_idle();
    repeat (IDLE_CYCLES) begin
      @(negedge clk);
      assert (!retire_valid)
        else stop_on_error($sformatf(
          "** Error at time %0t: test %s retired extra x%0d = %h",
          $time, test_name, retire_rd, retire_value));
    end
  endtask

  task automatic run_test();
    load_program();
    foreach (exp_rd[i]) begin
      expect_retire(exp_rd[i], exp_value[i], i);
    end
    check_idle();
    tests_run++;
    $display("Test %s: %0d retires matched", test_name, exp_rd.size());
  endtask

  task automatic parse_line(input string line);
    logic [31:0] field_a;
    logic [31:0] field_b;
    string       name;
    int          n;
    if (line.len() > 0) begin
      case (line[0])
        "T": begin
          n = $sscanf(line, "T %s", name);
          test_name = (n == 1) ? name : "unnamed";
          clear_test();
        end
        "P": begin
          n = $sscanf(line, "P %h %h", field_a, field_b);
          if (n != 2 || field_a >= IMEM_DEPTH) begin
            stop_on_error($sformatf("Bad program line in cases file: %s", line));
          end else begin
            prog[field_a[IDX_W-1:0]] = field_b;
          end
        end
        "E": begin
          n = $sscanf(line, "E %d %h", field_a, field_b);
          if (n != 2 || field_a > 31) begin
            stop_on_error($sformatf("Bad expect line in cases file: %s", line));
          end else begin
            exp_rd.push_back(field_a[4:0]);
            exp_value.push_back(field_b);
          end
        end
        "D": run_test();
        // Comments and blank lines
        default: begin
        end
      endcase
    end
  endtask

  initial begin
    int    fd;
    string line;
    rst_n      = 1'b0;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    tests_run  = 0;
    test_name  = "unnamed";
    clear_test();
    fd = $fopen("tests/program_cases.txt", "r");
    if (fd == 0) begin
      stop_on_error("Could not open tests/program_cases.txt");
    end else begin
      @(negedge clk);
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) > 0) begin
          parse_line(line);
        end
      end
      $fclose(fd);
      if (tests_run > 0) begin
        $display("ALL TESTS PASSED");
        $finish;
      end else begin
        stop_on_error("No test was found in tests/program_cases.txt");
      end
    end
  end

endmodule

// ==== tests/program_cases.txt ====
# T name | P word_addr instr (hex) | E rd (decimal) value (hex) | D runs the test
# P and E lines may carry a trailing note after the two fields
T alu_forwarding
P 0 00500093 addi x1, x0, 5
P 1 00308113 addi x2, x1, 3
P 2 002081b3 add x3, x1, x2
P 3 40118233 sub x4, x3, x1
P 4 003272b3 and x5, x4, x3
P 5 0012e333 or x6, x5, x1
P 6 002343b3 xor x7, x6, x2
P 7 ffd00493 addi x9, x0, -3
P 8 0014a433 slt x8, x9, x1
P 9 0090a533 slt x10, x1, x9
P a 123455b7 lui x11, 0x12345
P b 67858593 addi x11, x11, 0x678
E 1 00000005
E 2 00000008
E 3 0000000d
E 4 00000008
E 5 00000008
E 6 0000000d
E 7 00000005
E 9 fffffffd
E 8 00000001
E 10 00000000
E 11 12345000
E 11 12345678
D
T load_store
P 0 04000093 addi x1, x0, 0x40
P 1 07b00113 addi x2, x0, 123
P 2 0020a023 sw x2, 0(x1)
P 3 0000a183 lw x3, 0(x1)
P 4 00318233 add x4, x3, x3
P 5 0040a223 sw x4, 4(x1)
P 6 0040a283 lw x5, 4(x1)
P 7 40228333 sub x6, x5, x2
P 8 0000a383 lw x7, 0(x1)
P 9 00100493 addi x9, x0, 1
P a 00138413 addi x8, x7, 1
E 1 00000040
E 2 0000007b
E 3 0000007b
E 4 000000f6
E 5 000000f6
E 6 0000007b
E 7 0000007b
E 9 00000001
E 8 0000007c
D
T branches
P 0 00100093 addi x1, x0, 1
P 1 00100113 addi x2, x0, 1
P 2 00208663 beq x1, x2, +12 taken
P 3 01100193 addi x3, x0, 0x11
P 4 02200213 addi x4, x0, 0x22
P 5 03300293 addi x5, x0, 0x33
P 6 00209663 bne x1, x2, +12 not taken
P 7 04400313 addi x6, x0, 0x44
P 8 05500393 addi x7, x0, 0x55
P 9 00509663 bne x1, x5, +12 taken
P a 06600413 addi x8, x0, 0x66
P b 07700493 addi x9, x0, 0x77
P c 08800513 addi x10, x0, 0x88
E 1 00000001
E 2 00000001
E 5 00000033
E 6 00000044
E 7 00000055
E 10 00000088
D
T jal_and_x0
P 0 00900093 addi x1, x0, 9
P 1 00508013 addi x0, x1, 5
P 2 00100133 add x2, x0, x1
P 3 00c001ef jal x3, +12
P 4 00100213 addi x4, x0, 1
P 5 00200293 addi x5, x0, 2
P 6 00018333 add x6, x3, x0
P 7 0080006f jal x0, +8
P 8 00300393 addi x7, x0, 3
P 9 05a00413 addi x8, x0, 0x5a
E 1 00000009
E 2 00000009
E 3 00000010
E 6 00000010
E 8 0000005a
D

// ==== vlog.f ====
design/core_pkg.sv
design/fetch_unit.sv
design/decode_unit.sv
design/register_file.sv
design/execute_unit.sv
design/memory_unit.sv
design/hazard_unit.sv
design/processor_core.sv
tests/processor_core_asserts.sv
tests/processor_core_tb.sv

// ==== Makefile ====
TOP             ?= processor_core_tb
FILELIST        ?= vlog.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert
LINT_FLAGS      ?= --lint-only -Wall --timing
PASS_PATTERN    ?= ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@if grep -q "$(PASS_PATTERN)" $(LOG); then \
	  echo "Simulation passed, see $(LOG)"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
